//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;  // data and byte address

  // major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,  // register-immediate arithmetic
    op_reg    = 7'b0110011,  // register-register arithmetic
    op_misc   = 7'b0001111   // fence, executed as nop
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // access width, sz_none means no access
  typedef enum logic [1:0] {
    sz_none = 2'd0,
    sz_byte = 2'd1,
    sz_half = 2'd2,
    sz_word = 2'd3
  } mem_size_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic        funct7_30;  // sub / sra select
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
  } decoded_t;

  typedef struct packed {
    word_t     addr;       // byte address
    word_t     wdata;      // store data, low bits used for narrow stores
    mem_size_e we_size;    // store width
    mem_size_e re_size;    // load width
    logic      re_signed;  // sign extend the loaded value
  } mem_req_t;

  // memory-mapped output registers at the top of the address space
  localparam word_t led_addr = 32'hffff_fff0;
  localparam word_t out_addr = 32'hffff_fff4;

endpackage

`default_nettype wire

//--- source/decoder.sv
`default_nettype none
`timescale 1ns/1ps

module decoder (
  input  wire rv_pkg::word_t    instr,
  output rv_pkg::decoded_t      dec
);

  import rv_pkg::*;

  always_comb begin
    dec.opcode    = opcode_e'(instr[6:0]);  // unknown codes fall to nop in core
    dec.rd        = instr[11:7];
    dec.rs1       = instr[19:15];
    dec.rs2       = instr[24:20];
    dec.funct3    = instr[14:12];
    dec.funct7_30 = instr[30];

    // I format, loads, jalr, immediate ops
    dec.imm_i = {{20{instr[31]}}, instr[31:20]};

    // S format, split around rd field
    dec.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // B format, bit 0 always zero
    dec.imm_b = {
      {19{instr[31]}},
      instr[31],
      instr[7],
      instr[30:25],
      instr[11:8],
      1'b0
    };

    dec.imm_u = {instr[31:12], 12'b0};  // lui / auipc

    // J format, 21-bit signed offset
    dec.imm_j = {
      {11{instr[31]}},
      instr[31],
      instr[19:12],
      instr[20],
      instr[30:21],
      1'b0
    };
  end

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
  input  wire rv_pkg::alu_op_e op,
  input  wire rv_pkg::word_t   a,
  input  wire rv_pkg::word_t   b,
  output rv_pkg::word_t        y,
  output logic                 eq,   // a == b
  output logic                 lt,   // signed a < b
  output logic                 ltu   // unsigned a < b
);

  import rv_pkg::*;

  logic [4:0] shamt;  // shift amount, low bits of b only

  assign shamt = b[4:0];

  assign eq  = (a == b);
  assign lt  = ($signed(a) < $signed(b));
  assign ltu = (a < b);

  always_comb begin
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_sll:  y = a << shamt;
      alu_slt:  y = {31'b0, lt};   // reuse compare flags
      alu_sltu: y = {31'b0, ltu};
      alu_xor:  y = a ^ b;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = word_t'($signed(a) >>> shamt);  // keeps sign bit
      alu_or:   y = a | b;
      alu_and:  y = a & b;
      default:  y = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- source/registers.sv
`default_nettype none
`timescale 1ns/1ps

module registers (
  input  wire                clk,
  input  wire [4:0]          rs1,
  input  wire [4:0]          rs2,
  input  wire [4:0]          rd,
  input  wire                rd_we,
  input  wire rv_pkg::word_t rd_wd,
  input  wire                ld_we,  // delayed load write
  input  wire [4:0]          ld_rd,
  input  wire rv_pkg::word_t ld_wd,
  output rv_pkg::word_t      rd1,
  output rv_pkg::word_t      rd2
);

  import rv_pkg::*;

  word_t regs [32];  // x0 entry never written

  // asynchronous reads, x0 forced to zero
  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (ld_we && ld_rd != 5'd0) begin
      regs[ld_rd] <= ld_wd;  // load from previous instruction
    end
    // the younger instruction overrides the load on the same target
    if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_wd;
    end
  end

endmodule

`default_nettype wire

//--- source/core.sv
`default_nettype none
`timescale 1ns/1ps

module core (
  input  wire                clk,
  input  wire                rst,
  input  wire rv_pkg::word_t instr,       // word at previous fetch_addr
  output rv_pkg::word_t      fetch_addr,
  output rv_pkg::mem_req_t   mem_req,
  input  wire rv_pkg::word_t load_data    // extended, one cycle after load
);

  import rv_pkg::*;

  word_t    pc;         // address being fetched
  word_t    pc_ir;      // address of the instruction in execute
  word_t    pc_nxt;
  logic     is_bubble;  // current instruction is wrong-path
  logic     ld_we;      // previous instruction was a load
  logic [4:0] ld_rd;    // its destination

  decoded_t dec;
  word_t    rd1, rd2;
  word_t    rs1_val, rs2_val;  // operands after forwarding
  word_t    alu_b, alu_y;
  alu_op_e  alu_op;
  logic     eq, lt, ltu;
  logic     br_taken;
  logic     jump;               // redirect pc, bubble the next fetch
  word_t    jump_pc;
  logic     rd_we;
  word_t    rd_wd;

  function automatic mem_size_e size_of(input logic [1:0] f3);
    case (f3)
      2'd0:    return sz_byte;
      2'd1:    return sz_half;
      2'd2:    return sz_word;
      default: return sz_none;  // illegal width, no access
    endcase
  endfunction

  assign fetch_addr = pc;

  decoder u_decoder (.instr(instr), .dec(dec));

  registers u_registers (
    .clk(clk),
    .rs1(dec.rs1),
    .rs2(dec.rs2),
    .rd(dec.rd),
    .rd_we(rd_we),
    .rd_wd(rd_wd),
    .ld_we(ld_we),
    .ld_rd(ld_rd),
    .ld_wd(load_data),
    .rd1(rd1),
    .rd2(rd2)
  );

  // load data is not in the register file yet
  assign rs1_val = (ld_we && dec.rs1 == ld_rd) ? load_data : rd1;
  assign rs2_val = (ld_we && dec.rs2 == ld_rd) ? load_data : rd2;

  always_comb begin
    case (dec.opcode)
      op_reg, op_branch: alu_b = rs2_val;
      op_store:          alu_b = dec.imm_s;
      default:           alu_b = dec.imm_i;  // imm ops, loads, jalr
    endcase
  end

  always_comb begin
    alu_op = alu_add;  // address calc by default
    if (dec.opcode == op_reg || dec.opcode == op_imm) begin
      case (dec.funct3)
        3'b000:  alu_op = (dec.opcode == op_reg && dec.funct7_30) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = dec.funct7_30 ? alu_sra : alu_srl;
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end
  end

  alu u_alu (
    .op(alu_op),
    .a(rs1_val),
    .b(alu_b),
    .y(alu_y),
    .eq(eq),
    .lt(lt),
    .ltu(ltu)
  );

  always_comb begin
    case (dec.funct3)
      3'b000:  br_taken = eq;    // beq
      3'b001:  br_taken = !eq;   // bne
      3'b100:  br_taken = lt;    // blt
      3'b101:  br_taken = !lt;   // bge
      3'b110:  br_taken = ltu;   // bltu
      3'b111:  br_taken = !ltu;  // bgeu
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    rd_we   = 1'b0;
    rd_wd   = alu_y;
    mem_req = '0;
    jump    = 1'b0;
    jump_pc = pc_ir + dec.imm_b;
    if (!is_bubble) begin
      case (dec.opcode)
        op_lui: begin
          rd_we = 1'b1;
          rd_wd = dec.imm_u;
        end
        op_auipc: begin
          rd_we = 1'b1;
          rd_wd = pc_ir + dec.imm_u;
        end
        op_imm, op_reg: rd_we = 1'b1;  // result from alu
        op_jal: begin
          rd_we   = 1'b1;
          rd_wd   = pc_ir + 32'd4;  // link
          jump    = 1'b1;
          jump_pc = pc_ir + dec.imm_j;
        end
        op_jalr: begin
          rd_we   = 1'b1;
          rd_wd   = pc_ir + 32'd4;
          jump    = 1'b1;
          jump_pc = {alu_y[31:1], 1'b0};  // rs1 + imm, lsb cleared
        end
        op_branch: jump = br_taken;
        op_load: begin
          mem_req.addr      = alu_y;
          mem_req.re_size   = size_of(dec.funct3[1:0]);
          mem_req.re_signed = !dec.funct3[2];  // lbu / lhu clear bit
        end
        op_store: begin
          mem_req.addr    = alu_y;
          mem_req.wdata   = rs2_val;
          mem_req.we_size = size_of(dec.funct3[1:0]);
        end
        default: ;  // fence, system, csr as nop
      endcase
    end
  end

  assign pc_nxt = jump ? jump_pc : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      pc_ir     <= '0;
      is_bubble <= 1'b0;
      ld_we     <= 1'b0;
    end else begin
      pc        <= pc_nxt;
      pc_ir     <= pc_nxt - 32'd4;  // fetch runs one word ahead
      is_bubble <= jump;            // word fetched now is wrong-path
      ld_we     <= !is_bubble && dec.opcode == op_load && dec.rd != 5'd0;
    end
    ld_rd <= dec.rd;
  end

endmodule

`default_nettype wire

//--- source/ram_io.sv
`default_nettype none
`timescale 1ns/1ps

module ram_io #(
  parameter int ram_depth_bitwidth = 10  // word address width
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire rv_pkg::mem_req_t        mem_req,    // port A, data
  output rv_pkg::word_t                load_data,
  input  wire rv_pkg::word_t           fetch_addr, // port B, instructions
  output rv_pkg::word_t                instr,
  input  wire                          prog_we,
  input  wire [ram_depth_bitwidth-1:0] prog_addr,
  input  wire rv_pkg::word_t           prog_data,
  output logic [5:0]                   led,
  output logic                         out_valid,
  output rv_pkg::word_t                out_data
);

  import rv_pkg::*;

  localparam int    depth     = 2 ** ram_depth_bitwidth;
  localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

  word_t mem [depth];

  logic [ram_depth_bitwidth-1:0] a_idx, b_idx;  // word indexes
  logic       is_led, is_out;
  logic       io_we, ram_we;
  logic [3:0] be;         // byte lanes to write
  word_t      lane_data;  // store data replicated into lanes

  word_t      ld_word;    // raw word read on port A
  logic [1:0] ld_off;     // byte offset of the load
  mem_size_e  ld_size;
  logic       ld_signed;
  logic [7:0]  lane_b;
  logic [15:0] lane_h;

  assign a_idx = mem_req.addr[ram_depth_bitwidth+1:2];
  assign b_idx = fetch_addr[ram_depth_bitwidth+1:2];  // low bits ignored

  // io registers are decoded ahead of the array
  assign is_led = (mem_req.addr == led_addr);
  assign is_out = (mem_req.addr == out_addr);
  assign io_we  = (mem_req.we_size != sz_none);
  assign ram_we = io_we && !is_led && !is_out;

  always_comb begin
    case (mem_req.we_size)
      sz_byte: begin
        be        = 4'b0001 << mem_req.addr[1:0];
        lane_data = {4{mem_req.wdata[7:0]}};
      end
      sz_half: begin
        be        = 4'b0011 << {mem_req.addr[1], 1'b0};
        lane_data = {2{mem_req.wdata[15:0]}};
      end
      sz_word: begin
        be        = 4'b1111;
        lane_data = mem_req.wdata;
      end
      default: begin
        be        = 4'b0000;
        lane_data = mem_req.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if (prog_we) mem[prog_addr] <= prog_data;  // program load
    end else if (ram_we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[a_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      instr <= nop_instr;  // stale word never executes after reset
    end else begin
      instr <= mem[b_idx];
    end
    ld_word   <= mem[a_idx];
    ld_off    <= mem_req.addr[1:0];
    ld_size   <= mem_req.re_size;
    ld_signed <= mem_req.re_signed;
  end

  // lane select and extension in the cycle after the read
  assign lane_b = ld_word[ld_off*8 +: 8];
  assign lane_h = ld_word[ld_off[1]*16 +: 16];

  always_comb begin
    case (ld_size)
      sz_byte: load_data = {{24{ld_signed & lane_b[7]}}, lane_b};
      sz_half: load_data = {{16{ld_signed & lane_h[15]}}, lane_h};
      default: load_data = ld_word;  // word
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led       <= '0;
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= io_we && is_out;  // one pulse per store
      if (io_we && is_led) led <= mem_req.wdata[5:0];
      if (io_we && is_out) out_data <= mem_req.wdata;
    end
  end

endmodule

`default_nettype wire

//--- source/soc.sv
`default_nettype none
`timescale 1ns/1ps

module soc #(
  parameter int ram_depth_bitwidth = 10  // 4 KiB of words by default
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          prog_we,    // only while rst is high
  input  wire [ram_depth_bitwidth-1:0] prog_addr,  // word address
  input  wire rv_pkg::word_t           prog_data,
  output logic [5:0]                   led,
  output logic                         out_valid,
  output rv_pkg::word_t                out_data
);

  import rv_pkg::*;

  word_t    instr;       // port B read data
  word_t    fetch_addr;  // pc
  word_t    load_data;   // port A read data, extended
  mem_req_t mem_req;     // port A request from execute

  core u_core (
    .clk(clk),
    .rst(rst),
    .instr(instr),
    .fetch_addr(fetch_addr),
    .mem_req(mem_req),
    .load_data(load_data)
  );

  ram_io #(
    .ram_depth_bitwidth(ram_depth_bitwidth)
  ) u_ram_io (
    .clk(clk),
    .rst(rst),
    .mem_req(mem_req),
    .load_data(load_data),
    .fetch_addr(fetch_addr),
    .instr(instr),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .led(led),
    .out_valid(out_valid),
    .out_data(out_data)
  );

endmodule

`default_nettype wire

//--- test/tb_soc.sv
`default_nettype none
`timescale 1ns/1ps

module tb_soc;

  import rv_pkg::*;

  localparam int addr_bits = 10;  // word address width of the memory

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 prog_we;
  logic [addr_bits-1:0] prog_addr;
  word_t                prog_data;
  logic [5:0]           led;
  logic                 out_valid;
  word_t                out_data;

  word_t prog[$];            // program being assembled
  word_t exp_q[$];           // expected out_data sequence
  word_t lfsr = 32'h8efe;
  int    errors = 0;
  int    checks = 0;
  int    pulses = 0;         // out_valid pulses seen

  soc #(
    .ram_depth_bitwidth(addr_bits)
  ) DUT (
    .clk(clk),
    .rst(rst),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .led(led),
    .out_valid(out_valid),
    .out_data(out_data)
  );

  always #50 clk = ~clk;  // 100 ns period

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic word_t next_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                   input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
  endfunction

  function automatic word_t i_type(input opcode_e op, input int imm, input int rs1,
                                   input int f3, input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t s_type(input int imm, input int rs2, input int rs1, input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(input int off, input int rs2, input int rs1, input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t u_type(input opcode_e op, input word_t imm, input int rd);
    return {imm[31:12], rd[4:0], op};
  endfunction

  function automatic word_t j_type(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
  endfunction

  // rv32i integer ops by funct3 with alt from instruction bit 30
  function automatic word_t alu_ref(input int f3, input logic alt, input word_t a, input word_t b);
    case (f3)
      0:       return alt ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return {31'b0, $signed(a) < $signed(b)};
      3:       return {31'b0, a < b};
      4:       return a ^ b;
      5:       return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input int f3, input word_t a, input word_t b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      5:       return $signed(a) >= $signed(b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t sext8(input logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic word_t sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic int pc_here();
    return prog.size() * 4;  // byte address of the next emitted word
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  // lui then addi with 0x800 added to undo the addi sign extension
  task automatic li(input int rd, input word_t v);
    emit(u_type(op_lui, v + 32'h800, rd));
    emit(i_type(op_imm, int'(v), rd, 0, rd));
  endtask

  task automatic store_out(input int rs);
    emit(s_type(4, rs, 30, 2));  // sw rs, 4(x30)
  endtask

  task automatic store_led(input int rs);
    emit(s_type(0, rs, 30, 2));  // sw rs, 0(x30)
  endtask

  task automatic start_prog();
    prog.delete();
    exp_q.delete();
    li(30, led_addr);  // x30 = io base
  endtask

  task automatic halt();
    emit(j_type(0, 0));  // jal x0, 0
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_led(input string name, input logic [5:0] expected,
                           input logic [5:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s led: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("mismatch %s pulse count: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // program port works only under reset
  task automatic load_program();
    @(negedge clk);
    rst = 1'b1;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = i[addr_bits-1:0];
      prog_data = prog[i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_out(input string name, output logic got);
    got = 1'b0;
    for (int t = 0; t < 2000 && !got; t++) begin
      @(negedge clk);
      if (out_valid) begin
        got = 1'b1;
        pulses++;
      end
    end
    if (!got) begin
      errors++;
      $display("%s: no out_valid pulse within 2000 cycles", name);
    end
  endtask

  task automatic wait_led(input string name, input logic [5:0] marker);
    logic seen;
    seen = 1'b0;
    for (int t = 0; t < 2000 && !seen; t++) begin
      @(negedge clk);
      if (out_valid) pulses++;
      seen = (led == marker);
    end
    if (!seen) begin
      errors++;
      $display("%s: led did not show %h within 2000 cycles", name, marker);
    end
  endtask

  task automatic expect_outputs(input string name);
    logic got;
    got = 1'b1;
    for (int i = 0; i < exp_q.size() && got; i++) begin
      wait_out(name, got);
      if (got) check_word(name, exp_q[i], out_data);
    end
  endtask

  task automatic test_alu();
    word_t a, b, t, r;
    start_prog();
    for (int p = 0; p < 2; p++) begin
      a = next_bits(32) | 32'h8000_0000;  // negative for sra and slt vs sltu
      b = next_bits(32) & 32'h7fff_ffff;
      if (p == 1) begin
        t = a;
        a = b;
        b = t;
      end
      li(1, a);
      li(2, b);
      for (int f = 0; f < 8; f++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if (alt == 0 || f == 0 || f == 5) begin  // sub, sra
            emit(r_type(alt * 32, 2, 1, f, 3));
            store_out(3);
            exp_q.push_back(alu_ref(f, alt == 1, a, b));
          end
          if (alt == 0 || f == 5) begin  // srai
            r = next_bits(12);
            if (f == 1 || f == 5) r = (alt == 1 ? 32'h400 : 32'h0) | {27'b0, r[4:0]};
            emit(i_type(op_imm, r, 1, f, 3));
            store_out(3);
            exp_q.push_back(alu_ref(f, alt == 1, a, {{20{r[11]}}, r[11:0]}));
          end
        end
      end
    end
    halt();
    load_program();
    expect_outputs("alu");
  endtask

  // load, use the result at once, store it out
  task automatic load_use(input int f3, input int off, input word_t loaded, input word_t mask);
    emit(i_type(op_load, off, 10, f3, 12));
    emit(r_type(0, 14, 12, 4, 13));  // xor x13, x12, x14
    store_out(13);
    exp_q.push_back(loaded ^ mask);
  endtask

  task automatic test_mem();
    word_t       mask, w, v;
    logic [7:0]  bt [4];
    logic [15:0] ht [2];
    logic [7:0]  b1;
    logic [15:0] h1;
    start_prog();
    mask = next_bits(32);
    li(10, 32'h800);  // data base
    li(14, mask);
    w = next_bits(32);
    li(5, w);
    emit(s_type(0, 5, 10, 2));  // sw
    v  = next_bits(32);
    b1 = v[7:0];
    li(6, v);
    emit(s_type(1, 6, 10, 0));  // sb over byte 1
    v  = next_bits(32);
    h1 = v[15:0];
    li(7, v);
    emit(s_type(2, 7, 10, 1));  // sh over upper half
    for (int k = 0; k < 4; k++) begin
      v = next_bits(32);
      if (k == 1) v[7] = 1'b1;
      if (k == 2) v[7] = 1'b0;
      bt[k] = v[7:0];
      li(6, v);
      emit(s_type(4 + k, 6, 10, 0));
    end
    for (int j = 0; j < 2; j++) begin
      v     = next_bits(32);
      v[15] = (j == 0);  // one negative half, one positive
      ht[j] = v[15:0];
      li(7, v);
      emit(s_type(8 + 2 * j, 7, 10, 1));
    end
    emit(i_type(op_load, 0, 10, 2, 12));  // lw forwarded as store data
    store_out(12);
    exp_q.push_back({h1, b1, w[7:0]});
    for (int k = 0; k < 4; k++) begin
      load_use(0, 4 + k, sext8(bt[k]), mask);     // lb
      load_use(4, 4 + k, {24'b0, bt[k]}, mask);   // lbu
    end
    for (int j = 0; j < 2; j++) begin
      load_use(1, 8 + 2 * j, sext16(ht[j]), mask);    // lh
      load_use(5, 8 + 2 * j, {16'b0, ht[j]}, mask);   // lhu
    end
    load_use(2, 4, {bt[3], bt[2], bt[1], bt[0]}, mask);
    halt();
    load_program();
    expect_outputs("load_store");
  endtask

  task automatic test_branch();
    word_t pa [4];
    word_t pb [4];
    int    f3s [6];
    int    n;
    word_t r;
    pa  = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h7fff_ffff};
    pb  = '{32'h7fff_ffff, 32'h0000_0001, 32'h0, 32'h8000_0000};
    f3s = '{0, 1, 4, 5, 6, 7};
    r     = next_bits(32);
    pa[2] = r;  // equal pair
    pb[2] = r;
    n = int'(next_bits(5) % 20) + 1;
    start_prog();
    emit(i_type(op_imm, n, 0, 0, 1));   // x1 = n
    emit(i_type(op_imm, 0, 0, 0, 2));   // x2 = 0
    emit(r_type(0, 1, 2, 0, 2));        // loop start, x2 += x1
    emit(i_type(op_imm, -1, 1, 0, 1));
    emit(b_type(-8, 0, 1, 1));          // bne x1, x0, loop
    store_out(2);
    exp_q.push_back(word_t'(n * (n + 1) / 2));
    for (int p = 0; p < 4; p++) begin
      li(5, pa[p]);
      li(6, pb[p]);
      foreach (f3s[k]) begin
        emit(b_type(12, 6, 5, f3s[k]));    // taken goes to marker 2
        emit(i_type(op_imm, 1, 0, 0, 7));
        emit(j_type(8, 0));
        emit(i_type(op_imm, 2, 0, 0, 7));
        store_out(7);
        exp_q.push_back(branch_ref(f3s[k], pa[p], pb[p]) ? 32'd2 : 32'd1);
      end
    end
    halt();
    load_program();
    expect_outputs("branch");
  endtask

  task automatic test_jump();
    int sub_pc, c1, c2;
    start_prog();
    sub_pc = pc_here() + 40;  // subroutine after the ten main words
    emit(i_type(op_imm, 7, 0, 0, 9));          // x9 = 7
    c1 = pc_here();
    emit(j_type(sub_pc - c1, 1));              // jal x1, sub
    store_out(1);
    emit(i_type(op_imm, sub_pc + 1, 0, 0, 5)); // odd target with bit 0 dropped
    c2 = pc_here();
    emit(i_type(op_jalr, 0, 5, 0, 1));         // jalr x1, 0(x5)
    store_out(1);
    emit(j_type(8, 0));
    emit(i_type(op_imm, 100, 9, 0, 9));        // jumped over
    store_out(9);
    halt();
    emit(i_type(op_imm, 1, 9, 0, 9));          // subroutine adds 1 to x9
    emit(i_type(op_jalr, 0, 1, 0, 0));         // return
    emit(i_type(op_imm, 100, 9, 0, 9));        // wrong path after return
    exp_q.push_back(word_t'(c1 + 4));
    exp_q.push_back(word_t'(c2 + 4));
    exp_q.push_back(32'd9);
    load_program();
    expect_outputs("jump");
  endtask

  task automatic test_io();
    word_t      vals [4];
    logic [5:0] marker;
    logic       got;
    start_prog();
    foreach (vals[i]) begin
      vals[i] = next_bits(32);
      li(5, vals[i]);
      store_led(5);
      store_out(5);
    end
    marker = ~vals[3][5:0];  // differs from the last led value
    emit(i_type(op_imm, int'(marker), 0, 0, 6));
    store_led(6);
    halt();
    pulses = 0;
    load_program();
    got = 1'b1;
    for (int i = 0; i < 4 && got; i++) begin
      wait_out("io", got);
      if (got) begin
        check_word("io", vals[i], out_data);
        check_led("io", vals[i][5:0], led);
      end
    end
    wait_led("io", marker);
    check_count("io", 4, pulses);
  endtask

  task automatic test_restart();
    start_prog();
    emit(i_type(op_imm, 0, 0, 0, 5));  // x5 = 0
    emit(i_type(op_imm, 1, 5, 0, 5));  // loop start, x5 += 1
    store_out(5);
    store_led(5);
    emit(j_type(-12, 0));
    for (int i = 1; i <= 3; i++) exp_q.push_back(word_t'(i));
    load_program();
    expect_outputs("restart");
    @(negedge clk);
    rst = 1'b1;  // mid-loop reset keeps the program in memory
    repeat (2) @(negedge clk);
    check_led("restart", 6'd0, led);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    expect_outputs("restart");  // sequence starts over at 1
  endtask

  initial begin
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    test_alu();
    test_mem();
    test_branch();
    test_jump();
    test_io();
    test_restart();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
source/rv_pkg.sv
source/decoder.sv
source/alu.sv
source/registers.sv
source/core.sv
source/ram_io.sv
source/soc.sv
test/tb_soc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# show the output, then fail unless the pass line is in it
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
